/* source/gb_bus_defs.svh */
// Memory bus fabric constants
// Bus and flash widths, work RAM size and the console address map

`ifndef GB_BUS_DEFS_SVH
`define GB_BUS_DEFS_SVH

// Widths
`define ADDR_WIDTH        16
`define DATA_WIDTH        8
`define FLASH_ADDR_WIDTH  24

// Work RAM sizing
`define WRAM_DEPTH        8192
`define WRAM_ADDR_WIDTH   13

// Cartridge and boot image, both in flash
`define CART_START        16'h0000
`define CART_END          16'h7FFF
`define BOOT_END          16'h0103
`define CART_FLASH_OFFSET 16'h0104

// Work RAM and its echo window
`define WRAM_START        16'hC000
`define WRAM_END          16'hDFFF
`define ECHO_START        16'hE000
`define ECHO_END          16'hFDFF

// Memory mapped registers
`define MMIO_IF           16'hFF0F
`define MMIO_BOOT         16'hFF50
`define MMIO_IE           16'hFFFF

`endif

/* source/gb_bus_pkg.sv */
// Memory bus fabric types
// Address and data types, decoded regions and interrupt bit positions

package gb_bus_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;
   typedef logic [12:0] wram_addr_t;
   typedef logic [23:0] flash_addr_t;

   // One region per responder class
   typedef enum logic [2:0] {
      REGION_BOOT_FLASH,
      REGION_CART,
      REGION_WRAM,
      REGION_ECHO,
      REGION_BOOT_REG,
      REGION_IF,
      REGION_IE,
      REGION_UNMAPPED
   } region_t;

   // Bit positions inside IF and IE
   typedef enum logic [2:0] {
      INT_VBLANK = 3'd0,
      INT_LCDC   = 3'd1,
      INT_TIMER  = 3'd2,
      INT_SERIAL = 3'd3,
      INT_JOYPAD = 3'd4
   } int_bit_t;

   typedef logic [4:0] int_flags_t;

endpackage

/* source/bus_decode_if.sv */
// Decoded bus request
// One request per cycle, already classified by region

`timescale 1ns/1ps

interface bus_decode_if;

   gb_bus_pkg::region_t    region;
   gb_bus_pkg::wram_addr_t wram_addr;
   gb_bus_pkg::data_t      write_data;
   logic                   write_en;
   logic                   read_en;

   modport decoder (
      output region, wram_addr, write_data, write_en, read_en
   );

   modport responder (
      input region, wram_addr, write_data, write_en, read_en
   );

   // Read combiner only needs to know where the read went
   modport combiner (
      input region, read_en
   );

endinterface

/* source/address_decoder.sv */
// Address decoder
// Classifies the bus address into a region, applies the boot overlay
// and computes the work RAM index and the external flash address

`timescale 1ns/1ps
`include "gb_bus_defs.svh"

module address_decoder (
   input  gb_bus_pkg::addr_t       addr,
   input  gb_bus_pkg::data_t       write_data,
   input  logic                    mem_we,
   input  logic                    mem_re,
   input  logic                    boot_done,
   output gb_bus_pkg::flash_addr_t flash_addr,
   bus_decode_if.decoder           dec
);

   gb_bus_pkg::addr_t cart_addr;
   gb_bus_pkg::addr_t wram_offset;
   gb_bus_pkg::addr_t echo_offset;

   // Cartridge image sits behind the boot image in flash, wraps at 16 bits
   assign cart_addr   = addr + `CART_FLASH_OFFSET;
   assign wram_offset = addr - `WRAM_START;
   assign echo_offset = addr - `ECHO_START;

   always_comb begin
      dec.region    = gb_bus_pkg::REGION_UNMAPPED;
      dec.wram_addr = wram_offset[`WRAM_ADDR_WIDTH-1:0];
      flash_addr    = {{(`FLASH_ADDR_WIDTH-`ADDR_WIDTH){1'b0}}, addr};

      if (!boot_done && addr <= `BOOT_END) begin
         dec.region = gb_bus_pkg::REGION_BOOT_FLASH;
      end else if (addr <= `CART_END) begin
         dec.region = gb_bus_pkg::REGION_CART;
         flash_addr = {{(`FLASH_ADDR_WIDTH-`ADDR_WIDTH){1'b0}}, cart_addr};
      end else if (addr >= `WRAM_START && addr <= `WRAM_END) begin
         dec.region = gb_bus_pkg::REGION_WRAM;
      end else if (addr >= `ECHO_START && addr <= `ECHO_END) begin
         dec.region    = gb_bus_pkg::REGION_ECHO;
         dec.wram_addr = echo_offset[`WRAM_ADDR_WIDTH-1:0];
      end else if (addr == `MMIO_BOOT) begin
         dec.region = gb_bus_pkg::REGION_BOOT_REG;
      end else if (addr == `MMIO_IF) begin
         dec.region = gb_bus_pkg::REGION_IF;
      end else if (addr == `MMIO_IE) begin
         dec.region = gb_bus_pkg::REGION_IE;
      end
   end

   // Strobes and payload pass straight through
   assign dec.write_data = write_data;
   assign dec.write_en   = mem_we;
   assign dec.read_en    = mem_re;

   // Single master, one access per cycle
   always_comb begin
      assert final (!(mem_we && mem_re))
         else $error("address_decoder: read and write strobes high together");
   end

endmodule

/* source/wram_bank.sv */
// Work RAM bank
// 8 KiB synchronous single-port RAM behind the work RAM and echo windows

`timescale 1ns/1ps

module wram_bank (
   input  logic              clock,
   bus_decode_if.responder   dec,
   output gb_bus_pkg::data_t wram_data
);

   localparam int unsigned DEPTH = 2 ** $bits(gb_bus_pkg::wram_addr_t);

   gb_bus_pkg::data_t mem [DEPTH];
   logic              in_window;

   // Echo window aliases the same storage
   assign in_window = (dec.region == gb_bus_pkg::REGION_WRAM) ||
                      (dec.region == gb_bus_pkg::REGION_ECHO);

   always_ff @(posedge clock) begin
      if (dec.write_en && in_window) begin
         mem[dec.wram_addr] <= dec.write_data;
      end
   end

   // Read port runs every cycle, combiner picks it up when needed
   always_ff @(posedge clock) begin
      wram_data <= mem[dec.wram_addr];
   end

endmodule

/* source/io_registers.sv */
// I/O registers
// Boot-disable register, interrupt flags (IF) and interrupt enable (IE),
// with request line merging and the pending interrupt summary

`timescale 1ns/1ps

module io_registers (
   input  logic              clock,
   input  logic              reset,
   bus_decode_if.responder   dec,
   input  logic              irq_vblank,
   input  logic              irq_lcdc,
   input  logic              irq_timer,
   input  logic              irq_joypad,
   output gb_bus_pkg::data_t reg_data,
   output logic              boot_done,
   output logic              irq_pending
);

   gb_bus_pkg::data_t      boot_reg;
   gb_bus_pkg::int_flags_t if_reg;
   gb_bus_pkg::int_flags_t ie_reg;
   gb_bus_pkg::int_flags_t irq_lines;
   logic                   if_write;

   // Serial has no source in this design
   always_comb begin
      irq_lines                         = '0;
      irq_lines[gb_bus_pkg::INT_VBLANK] = irq_vblank;
      irq_lines[gb_bus_pkg::INT_LCDC]   = irq_lcdc;
      irq_lines[gb_bus_pkg::INT_TIMER]  = irq_timer;
      irq_lines[gb_bus_pkg::INT_JOYPAD] = irq_joypad;
   end

   assign if_write = dec.write_en && (dec.region == gb_bus_pkg::REGION_IF);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         boot_reg <= '0;
         if_reg   <= '0;
         ie_reg   <= '0;
      end else begin
         if (dec.write_en && dec.region == gb_bus_pkg::REGION_BOOT_REG) begin
            boot_reg <= dec.write_data;
         end
         if (dec.write_en && dec.region == gb_bus_pkg::REGION_IE) begin
            ie_reg <= dec.write_data[4:0];
         end
         // A CPU write wins over requests arriving in the same cycle
         if (if_write) begin
            if_reg <= dec.write_data[4:0];
         end else begin
            if_reg <= if_reg | irq_lines;
         end
      end
   end

   always_comb begin
      case (dec.region)
         gb_bus_pkg::REGION_IF:       reg_data = {3'b000, if_reg};
         gb_bus_pkg::REGION_IE:       reg_data = {3'b000, ie_reg};
         gb_bus_pkg::REGION_BOOT_REG: reg_data = boot_reg;
         default:                     reg_data = 8'h00;
      endcase
   end

   assign boot_done   = boot_reg[0];
   assign irq_pending = |(if_reg & ie_reg);

   a_serial_only_by_write: assert property (
      @(posedge clock) disable iff (reset)
      (!if_reg[gb_bus_pkg::INT_SERIAL] && !if_write) |=> !if_reg[gb_bus_pkg::INT_SERIAL]
   ) else $error("io_registers: serial flag set without a write to IF");

endmodule

/* source/read_mux.sv */
// Read combiner
// Latches the byte of the addressed region one cycle after the read
// request and raises read_valid for that cycle

`timescale 1ns/1ps

module read_mux (
   input  logic              clock,
   input  logic              reset,
   bus_decode_if.combiner    dec,
   input  gb_bus_pkg::data_t wram_data,
   input  gb_bus_pkg::data_t reg_data,
   input  gb_bus_pkg::data_t flash_data,
   output gb_bus_pkg::data_t read_data,
   output logic              read_valid
);

   gb_bus_pkg::data_t next_byte;
   gb_bus_pkg::data_t held_byte;
   logic              is_wram;
   logic              sel_wram;

   assign is_wram = (dec.region == gb_bus_pkg::REGION_WRAM) ||
                    (dec.region == gb_bus_pkg::REGION_ECHO);

   // Flash and register bytes are only stable during the request cycle
   always_comb begin
      case (dec.region)
         gb_bus_pkg::REGION_BOOT_FLASH,
         gb_bus_pkg::REGION_CART:     next_byte = flash_data;
         gb_bus_pkg::REGION_BOOT_REG,
         gb_bus_pkg::REGION_IF,
         gb_bus_pkg::REGION_IE:       next_byte = reg_data;
         default:                     next_byte = 8'h00;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         read_valid <= 1'b0;
         sel_wram   <= 1'b0;
      end else begin
         read_valid <= dec.read_en;
         sel_wram   <= is_wram;
      end
   end

   always_ff @(posedge clock) begin
      held_byte <= next_byte;
   end

   // RAM output is already registered inside the bank
   assign read_data = sel_wram ? wram_data : held_byte;

   a_valid_follows_read: assert property (
      @(posedge clock) disable iff (reset) read_valid |-> $past(dec.read_en)
   ) else $error("read_mux: read_valid without a read one cycle earlier");

endmodule

/* source/gb_bus_top.sv */
// Memory bus fabric top level
// Decoder, work RAM, I/O registers and read combiner of the console core,
// with the flash data bus and interrupt request lines as plain ports

`timescale 1ns/1ps
`include "gb_bus_defs.svh"

module gb_bus_top (
   input  logic                         clock,
   input  logic                         reset,
   input  logic [`ADDR_WIDTH-1:0]       addr,
   input  logic [`DATA_WIDTH-1:0]       write_data,
   input  logic                         mem_we,
   input  logic                         mem_re,
   input  logic                         irq_vblank,
   input  logic                         irq_lcdc,
   input  logic                         irq_timer,
   input  logic                         irq_joypad,
   input  logic [`DATA_WIDTH-1:0]       flash_data,
   output logic [`FLASH_ADDR_WIDTH-1:0] flash_addr,
   output logic [`DATA_WIDTH-1:0]       read_data,
   output logic                         read_valid,
   output logic                         boot_done,
   output logic                         irq_pending
);

   logic [`DATA_WIDTH-1:0] wram_data;
   logic [`DATA_WIDTH-1:0] reg_data;

   bus_decode_if dec_bus ();

   address_decoder u_decoder (
      .addr       (addr),
      .write_data (write_data),
      .mem_we     (mem_we),
      .mem_re     (mem_re),
      .boot_done  (boot_done),
      .flash_addr (flash_addr),
      .dec        (dec_bus.decoder)
   );

   wram_bank u_wram (
      .clock     (clock),
      .dec       (dec_bus.responder),
      .wram_data (wram_data)
   );

   io_registers u_io_regs (
      .clock       (clock),
      .reset       (reset),
      .dec         (dec_bus.responder),
      .irq_vblank  (irq_vblank),
      .irq_lcdc    (irq_lcdc),
      .irq_timer   (irq_timer),
      .irq_joypad  (irq_joypad),
      .reg_data    (reg_data),
      .boot_done   (boot_done),
      .irq_pending (irq_pending)
   );

   read_mux u_read_mux (
      .clock      (clock),
      .reset      (reset),
      .dec        (dec_bus.combiner),
      .wram_data  (wram_data),
      .reg_data   (reg_data),
      .flash_data (flash_data),
      .read_data  (read_data),
      .read_valid (read_valid)
   );

endmodule

/* test/gb_bus_checker.sv */
// Memory bus fabric checker
// Reference model of the address map, work RAM, boot register, IF and IE.
// Compares read responses, flash addresses and the status outputs.

`timescale 1ns/1ps
`include "gb_bus_defs.svh"

module gb_bus_checker (
   input  logic        clock, reset, mem_we, mem_re, read_valid, boot_done, irq_pending,
   input  logic        irq_vblank, irq_lcdc, irq_timer, irq_joypad,
   input  logic [15:0] addr,
   input  logic [7:0]  write_data, read_data,
   input  logic [23:0] flash_addr,
   output int          check_count, error_count
);

   logic [7:0] wram [`WRAM_DEPTH];
   logic       known [`WRAM_DEPTH];
   logic [7:0] boot_reg;
   logic [4:0] if_reg, ie_reg;
   logic [7:0] exp_data;
   logic       exp_valid, exp_known;
   logic [3:0] last_status;

   initial begin
      check_count = 0;
      error_count = 0;
      foreach (known[i]) known[i] = 1'b0;
   end

   task automatic compare(input string what, input logic [23:0] got,
                          input logic [23:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
      end
   endtask

   // Model state moves at the same edge as the DUT state
   always @(posedge clock or posedge reset) begin
      logic [15:0] fa;
      logic [12:0] idx;
      logic        in_ram;
      if (reset) begin
         boot_reg  = 8'h00;
         if_reg    = 5'h00;
         ie_reg    = 5'h00;
         exp_valid = 1'b0;
      end else begin
         // Work RAM and echo windows are back to back
         in_ram = (addr >= `WRAM_START && addr <= `ECHO_END);
         idx    = (addr >= `ECHO_START) ? addr - `ECHO_START : addr - `WRAM_START;
         // Boot image overlays the cartridge start until disabled
         fa = (!boot_reg[0] && addr <= `BOOT_END) ? addr : addr + `CART_FLASH_OFFSET;
         exp_valid = mem_re;
         exp_known = !in_ram || known[idx];
         if (addr <= `CART_END) begin
            exp_data = fa[7:0] ^ fa[15:8];
            if (mem_re) compare("flash_addr", flash_addr, {8'h00, fa});
         end else if (in_ram) begin
            exp_data = wram[idx];
         end else begin
            case (addr)
               `MMIO_BOOT: exp_data = boot_reg;
               `MMIO_IF:   exp_data = {3'b000, if_reg};
               `MMIO_IE:   exp_data = {3'b000, ie_reg};
               default:    exp_data = 8'h00;
            endcase
         end
         if (mem_we && in_ram) begin
            wram[idx]  = write_data;
            known[idx] = 1'b1;
         end
         boot_reg = (mem_we && addr == `MMIO_BOOT) ? write_data : boot_reg;
         ie_reg   = (mem_we && addr == `MMIO_IE) ? write_data[4:0] : ie_reg;
         // Serial never has a request of its own
         if_reg   = (mem_we && addr == `MMIO_IF) ? write_data[4:0]
                  : if_reg | {irq_joypad, 1'b0, irq_timer, irq_lcdc, irq_vblank};
      end
   end

   // Registered outputs are stable at the falling edge
   always @(negedge clock) begin
      if (reset !== 1'b0) begin
         last_status = 'x;
      end else begin
         compare("read_valid", read_valid, exp_valid);
         if (exp_valid && exp_known) compare("read_data", read_data, exp_data);
         // Status outputs only when either side moves
         if ({boot_done, irq_pending, boot_reg[0], |(if_reg & ie_reg)} !== last_status) begin
            compare("boot_done", boot_done, boot_reg[0]);
            compare("irq_pending", irq_pending, |(if_reg & ie_reg));
         end
         last_status = {boot_done, irq_pending, boot_reg[0], |(if_reg & ie_reg)};
      end
   end

endmodule

/* test/gb_bus_tb.sv */
// Memory bus fabric testbench
// LFSR driven bus traffic and interrupt pulses, a combinational flash model,
// the DUT and the checker that compares it against the reference model

`timescale 1ns/1ps
`include "gb_bus_defs.svh"

module gb_bus_tb;

   logic        clock, reset, mem_we, mem_re;
   logic        irq_vblank, irq_lcdc, irq_timer, irq_joypad;
   logic [15:0] addr;
   logic [7:0]  write_data, flash_data, read_data;
   logic [23:0] flash_addr;
   logic        read_valid, boot_done, irq_pending;
   logic [31:0] lfsr_state;
   int          check_count, error_count;
   int          last_checks, last_errors;

   // Flash byte is a pure function of its address
   assign flash_data = flash_addr[7:0] ^ flash_addr[15:8];

   gb_bus_top uut (.*);
   gb_bus_checker u_checker (.*);

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         value      = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   task automatic bus_cycle(input logic we, input logic re, input logic [15:0] a,
                            input logic [7:0] d);
      @(negedge clock);
      mem_we     = we;
      mem_re     = re;
      addr       = a;
      write_data = d;
   endtask

   task automatic end_test(input string name);
      int waited;
      bus_cycle(1'b0, 1'b0, 16'h0000, 8'h00);
      {irq_joypad, irq_timer, irq_lcdc, irq_vblank} = 4'h0;
      waited = 0;
      // Drain the last read response
      while (read_valid) begin
         @(negedge clock);
         waited++;
         if (waited > 8) begin
            $display("Timeout: read_valid stayed high at the end of %s", name);
            $display("Done: errors found");
            $finish;
         end
      end
      // Checker compares on the falling edge, counts are settled here
      @(posedge clock);
      $display("%s: %0d checks, %0d errors", name, check_count - last_checks,
               error_count - last_errors);
      last_checks = check_count;
      last_errors = error_count;
   endtask

   initial begin
      logic [15:0] a;
      logic [12:0] base;
      logic [12:0] idx;
      lfsr_state  = 32'he81a818a;
      reset       = 1'b1;
      {mem_we, mem_re, addr, write_data} = '0;
      {irq_joypad, irq_timer, irq_lcdc, irq_vblank} = 4'h0;
      last_checks = 0;
      last_errors = 0;
      repeat (4) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;

      bus_cycle(1'b0, 1'b1, 16'h0000, 8'h00);
      end_test("Test 1 reset state");

      // Small block of work RAM so reads hit written bytes
      base = random_bits(12);
      repeat (150) begin
         idx = base + random_bits(5);
         a   = (random_bits(1) ? `ECHO_START : `WRAM_START) + idx;
         if (random_bits(1)) begin
            bus_cycle(1'b1, 1'b0, a, random_bits(8));
            // Read back at once through either window
            a = (random_bits(1) ? `ECHO_START : `WRAM_START) + idx;
         end
         bus_cycle(1'b0, 1'b1, a, 8'h00);
      end
      end_test("Test 2 work RAM and echo");

      bus_cycle(1'b0, 1'b1, 16'h0103, 8'h00);
      repeat (20) bus_cycle(1'b0, 1'b1, random_bits(15), 8'h00);
      bus_cycle(1'b1, 1'b0, `MMIO_BOOT, 8'h01);
      bus_cycle(1'b0, 1'b1, `MMIO_BOOT, 8'h00);
      bus_cycle(1'b0, 1'b1, 16'h0103, 8'h00);
      repeat (20) bus_cycle(1'b0, 1'b1, random_bits(8), 8'h00);
      end_test("Test 3 cartridge and boot disable");

      repeat (80) begin
         case (random_bits(2))
            2'd0:    bus_cycle(1'b0, 1'b1, `MMIO_IF, 8'h00);
            2'd1:    bus_cycle(1'b1, 1'b0, `MMIO_IE, random_bits(5));
            2'd2:    bus_cycle(1'b1, 1'b0, `MMIO_IF, random_bits(5));
            default: bus_cycle(1'b0, 1'b1, `MMIO_IE, 8'h00);
         endcase
         // Sparse request pulses
         {irq_joypad, irq_timer, irq_lcdc, irq_vblank} = random_bits(4) & random_bits(4);
      end
      end_test("Test 4 interrupt flags");

      repeat (60) begin
         a = random_bits(1) ? 16'h8000 + random_bits(14) : 16'hFE00 + random_bits(9);
         if (a != `MMIO_IF && a != `MMIO_BOOT && a != `MMIO_IE) begin
            bus_cycle(random_bits(1), 1'b0, a, random_bits(8));
            bus_cycle(1'b0, 1'b1, a, 8'h00);
         end
      end
      bus_cycle(1'b0, 1'b1, `MMIO_IE, 8'h00);
      bus_cycle(1'b0, 1'b1, `MMIO_BOOT, 8'h00);
      end_test("Test 5 unmapped addresses");

      $display("Totals: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* gb_bus.f */
+incdir+source
source/gb_bus_pkg.sv
source/bus_decode_if.sv
source/address_decoder.sv
source/wram_bank.sv
source/io_registers.sv
source/read_mux.sv
source/gb_bus_top.sv
test/gb_bus_checker.sv
test/gb_bus_tb.sv
